/* Makefile */
VERILATOR ?= verilator
TOP       ?= cp0_top_tb
FILELIST  ?= cp0_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* common/cp0_pkg.sv */
package cp0_pkg;

    typedef logic [31:0] cp0_word_t;
    // Register number in 7:3, select in 2:0.
    typedef logic [7:0]  cp0_addr_t;
    typedef logic [4:0]  exc_code_t;

    localparam int TLB_ENTRIES = 16;
    localparam int TLB_IDX_W   = 4;

    // Lo bodies hold EntryLo bits 25:1 (PFN, C, D, V).
    typedef struct packed {
        logic [18:0] vpn2;
        logic [7:0]  asid;
        logic        g;
        logic [24:0] lo0;
        logic [24:0] lo1;
    } tlb_entry_t;

    localparam cp0_addr_t CP0_INDEX    = {5'd0, 3'd0};
    localparam cp0_addr_t CP0_ENTRYLO0 = {5'd2, 3'd0};
    localparam cp0_addr_t CP0_ENTRYLO1 = {5'd3, 3'd0};
    localparam cp0_addr_t CP0_BADVADDR = {5'd8, 3'd0};
    localparam cp0_addr_t CP0_COUNT    = {5'd9, 3'd0};
    localparam cp0_addr_t CP0_ENTRYHI  = {5'd10, 3'd0};
    localparam cp0_addr_t CP0_COMPARE  = {5'd11, 3'd0};
    localparam cp0_addr_t CP0_STATUS   = {5'd12, 3'd0};
    localparam cp0_addr_t CP0_CAUSE    = {5'd13, 3'd0};
    localparam cp0_addr_t CP0_EPC      = {5'd14, 3'd0};

    localparam int STATUS_IE  = 0;
    localparam int STATUS_EXL = 1;
    localparam int STATUS_BEV = 22;
    localparam int CAUSE_BD   = 31;
    localparam int CAUSE_TI   = 30;

    localparam cp0_word_t STATUS_RESET = 32'h1 << STATUS_BEV;

    // Bits that mtc0 may change.
    localparam cp0_word_t INDEX_WMASK   = 32'h0000_000f;
    localparam cp0_word_t ENTRYLO_WMASK = 32'h03ff_ffff;
    localparam cp0_word_t ENTRYHI_WMASK = 32'hffff_e0ff;
    localparam cp0_word_t STATUS_WMASK  = 32'h0000_ff03;
    localparam cp0_word_t CAUSE_WMASK   = 32'h0000_0300;
    localparam cp0_word_t FULL_WMASK    = 32'hffff_ffff;

endpackage

/* common/cp0_timer_if.sv */
`timescale 1ns/1ps

interface cp0_timer_if;
    import cp0_pkg::*;

    logic       count_wr;
    logic       compare_wr;
    cp0_word_t  wdata;
    cp0_word_t  count;
    cp0_word_t  compare;
    logic       timer_int;

    modport master (
        output count_wr, compare_wr, wdata,
        input  count, compare, timer_int
    );

    modport slave (
        input  count_wr, compare_wr, wdata,
        output count, compare, timer_int
    );

endinterface

/* common/cp0_tlb_if.sv */
`timescale 1ns/1ps

interface cp0_tlb_if;
    import cp0_pkg::*;

    cp0_word_t              entryhi;
    cp0_word_t              entrylo0;
    cp0_word_t              entrylo1;
    cp0_word_t              index;

    logic                   probe_hit;
    logic [TLB_IDX_W-1:0]   probe_idx;
    // Entry selected by index.
    tlb_entry_t             rd_entry;

    modport master (
        output entryhi, entrylo0, entrylo1, index,
        input  probe_hit, probe_idx, rd_entry
    );

    modport slave (
        input  entryhi, entrylo0, entrylo1, index,
        output probe_hit, probe_idx, rd_entry
    );

endinterface

/* cp0/cp0_regs.sv */
`timescale 1ns/1ps

module cp0_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                rd_en,
    input  cp0_pkg::cp0_addr_t  rd_addr,
    output cp0_pkg::cp0_word_t  rd_data,
    input  logic                wr_en,
    input  cp0_pkg::cp0_addr_t  wr_addr,
    input  cp0_pkg::cp0_word_t  wr_data,
    input  logic [5:0]          hw_int,
    input  logic                exc_valid,
    input  cp0_pkg::exc_code_t  exc_code,
    input  logic                exc_bd,
    input  cp0_pkg::cp0_word_t  exc_epc,
    input  logic                exc_badvaddr_valid,
    input  cp0_pkg::cp0_word_t  exc_badvaddr,
    input  logic                eret,
    input  logic                tlbp,
    input  logic                tlbr,
    output cp0_pkg::cp0_word_t  epc,
    output logic                int_req,
    cp0_tlb_if.master           tlb,
    cp0_timer_if.master         tmr
);
    import cp0_pkg::*;

    cp0_word_t  index_q;
    cp0_word_t  status_q;
    logic       cause_bd_q;
    exc_code_t  cause_exc_q;
    logic [1:0] ip_sw_q;
    logic [5:0] hw_q;
    cp0_word_t  entryhi_q;
    cp0_word_t  entrylo0_q;
    cp0_word_t  entrylo1_q;
    cp0_word_t  badvaddr_q;
    cp0_word_t  epc_q;
    cp0_word_t  cause_val;
    cp0_word_t  cur_val;
    cp0_word_t  cur_mask;
    logic       bypass;

    // IP7 shares the timer interrupt with hw_int[5].
    always_comb begin
        cause_val = '0;
        cause_val[CAUSE_BD] = cause_bd_q;
        cause_val[CAUSE_TI] = tmr.timer_int;
        cause_val[15:8] = {hw_q[5] | tmr.timer_int, hw_q[4:0], ip_sw_q};
        cause_val[6:2] = cause_exc_q;
    end

    always_comb begin
        cur_val  = '0;
        cur_mask = '0;
        case (rd_addr)
            CP0_INDEX: begin
                cur_val  = index_q;
                cur_mask = INDEX_WMASK;
            end
            CP0_ENTRYLO0: begin
                cur_val  = entrylo0_q;
                cur_mask = ENTRYLO_WMASK;
            end
            CP0_ENTRYLO1: begin
                cur_val  = entrylo1_q;
                cur_mask = ENTRYLO_WMASK;
            end
            CP0_BADVADDR: cur_val = badvaddr_q;
            CP0_COUNT: begin
                cur_val  = tmr.count;
                cur_mask = FULL_WMASK;
            end
            CP0_ENTRYHI: begin
                cur_val  = entryhi_q;
                cur_mask = ENTRYHI_WMASK;
            end
            CP0_COMPARE: begin
                cur_val  = tmr.compare;
                cur_mask = FULL_WMASK;
            end
            CP0_STATUS: begin
                cur_val  = status_q;
                cur_mask = STATUS_WMASK;
            end
            CP0_CAUSE: begin
                cur_val  = cause_val;
                cur_mask = CAUSE_WMASK;
            end
            CP0_EPC: begin
                cur_val  = epc_q;
                cur_mask = FULL_WMASK;
            end
            default: ;
        endcase
    end

    // Same-cycle write shows the value the register would hold.
    assign bypass  = wr_en && (wr_addr == rd_addr);
    assign rd_data = !rd_en ? '0 :
                     bypass ? ((cur_val & ~cur_mask) | (wr_data & cur_mask)) : cur_val;

    assign tmr.count_wr   = wr_en && (wr_addr == CP0_COUNT);
    assign tmr.compare_wr = wr_en && (wr_addr == CP0_COMPARE);
    assign tmr.wdata      = wr_data;

    assign tlb.entryhi  = entryhi_q;
    assign tlb.entrylo0 = entrylo0_q;
    assign tlb.entrylo1 = entrylo1_q;
    assign tlb.index    = index_q;

    // Later assignments win.
    always_ff @(posedge clk) begin
        if (rst) begin
            index_q     <= '0;
            status_q    <= STATUS_RESET;
            cause_bd_q  <= 1'b0;
            cause_exc_q <= '0;
            ip_sw_q     <= '0;
            hw_q        <= '0;
        end else begin
            hw_q <= hw_int;
            if (wr_en) begin
                case (wr_addr)
                    CP0_INDEX:  index_q <= wr_data & INDEX_WMASK;
                    CP0_STATUS: status_q <= (status_q & ~STATUS_WMASK) | (wr_data & STATUS_WMASK);
                    CP0_CAUSE:  ip_sw_q <= wr_data[9:8];
                    default: ;
                endcase
            end
            if (tlbp) begin
                index_q <= {~tlb.probe_hit, {(31 - TLB_IDX_W){1'b0}}, tlb.probe_idx};
            end
            if (eret) begin
                status_q[STATUS_EXL] <= 1'b0;
            end
            if (exc_valid) begin
                status_q[STATUS_EXL] <= 1'b1;
                cause_exc_q          <= exc_code;
                cause_bd_q           <= exc_bd;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            case (wr_addr)
                CP0_ENTRYLO0: entrylo0_q <= wr_data & ENTRYLO_WMASK;
                CP0_ENTRYLO1: entrylo1_q <= wr_data & ENTRYLO_WMASK;
                CP0_ENTRYHI:  entryhi_q <= wr_data & ENTRYHI_WMASK;
                CP0_EPC:      epc_q <= wr_data;
                default: ;
            endcase
        end
        if (tlbr) begin
            entryhi_q  <= {tlb.rd_entry.vpn2, 5'd0, tlb.rd_entry.asid};
            entrylo0_q <= {6'd0, tlb.rd_entry.lo0, tlb.rd_entry.g};
            entrylo1_q <= {6'd0, tlb.rd_entry.lo1, tlb.rd_entry.g};
        end
        if (exc_valid) begin
            epc_q <= exc_epc;
            if (exc_badvaddr_valid) begin
                badvaddr_q <= exc_badvaddr;
            end
        end
    end

    assign epc     = epc_q;
    assign int_req = |(cause_val[15:8] & status_q[15:8]) &&
                     status_q[STATUS_IE] && !status_q[STATUS_EXL];

endmodule

/* cp0/cp0_timer.sv */
`timescale 1ns/1ps

module cp0_timer (
    input  logic        clk,
    input  logic        rst,
    cp0_timer_if.slave  tmr
);
    import cp0_pkg::*;

    // Count is the upper 32 bits, so it moves every other clock.
    logic [32:0]    count_q;
    cp0_word_t      compare_q;
    logic           ti_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q   <= '0;
            compare_q <= '0;
            ti_q      <= 1'b0;
        end else begin
            if (tmr.count_wr) begin
                count_q <= {tmr.wdata, 1'b0};
            end else begin
                count_q <= count_q + 33'd1;
            end

            // Writing Compare acknowledges the interrupt.
            if (tmr.compare_wr) begin
                compare_q <= tmr.wdata;
                ti_q      <= 1'b0;
            end else if (compare_q != '0 && tmr.count == compare_q) begin
                ti_q <= 1'b1;
            end
        end
    end

    assign tmr.count     = count_q[32:1];
    assign tmr.compare   = compare_q;
    assign tmr.timer_int = ti_q;

endmodule

/* cp0_top.f */
common/cp0_pkg.sv
common/cp0_tlb_if.sv
common/cp0_timer_if.sv
cp0/cp0_regs.sv
cp0/cp0_timer.sv
tlb/tlb_array.sv
design/cp0_top.sv
testbench/cp0_top_props.sv
testbench/cp0_top_tb.sv

/* design/cp0_top.sv */
`timescale 1ns/1ps

module cp0_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                rd_en,
    input  cp0_pkg::cp0_addr_t  rd_addr,
    output cp0_pkg::cp0_word_t  rd_data,
    input  logic                wr_en,
    input  cp0_pkg::cp0_addr_t  wr_addr,
    input  cp0_pkg::cp0_word_t  wr_data,
    input  logic [5:0]          hw_int,
    input  logic                exc_valid,
    input  cp0_pkg::exc_code_t  exc_code,
    input  logic                exc_bd,
    input  cp0_pkg::cp0_word_t  exc_epc,
    input  logic                exc_badvaddr_valid,
    input  cp0_pkg::cp0_word_t  exc_badvaddr,
    input  logic                eret,
    input  logic                tlbp,
    input  logic                tlbr,
    input  logic                tlbwi,
    output cp0_pkg::cp0_word_t  epc,
    output logic                int_req
);

    cp0_tlb_if   tlb_bus ();
    cp0_timer_if tmr_bus ();

    cp0_regs u_regs (
        .clk                (clk),
        .rst                (rst),
        .rd_en              (rd_en),
        .rd_addr            (rd_addr),
        .rd_data            (rd_data),
        .wr_en              (wr_en),
        .wr_addr            (wr_addr),
        .wr_data            (wr_data),
        .hw_int             (hw_int),
        .exc_valid          (exc_valid),
        .exc_code           (exc_code),
        .exc_bd             (exc_bd),
        .exc_epc            (exc_epc),
        .exc_badvaddr_valid (exc_badvaddr_valid),
        .exc_badvaddr       (exc_badvaddr),
        .eret               (eret),
        .tlbp               (tlbp),
        .tlbr               (tlbr),
        .epc                (epc),
        .int_req            (int_req),
        .tlb                (tlb_bus.master),
        .tmr                (tmr_bus.master)
    );

    cp0_timer u_timer (
        .clk    (clk),
        .rst    (rst),
        .tmr    (tmr_bus.slave)
    );

    tlb_array u_tlb (
        .clk    (clk),
        .tlbwi  (tlbwi),
        .tlb    (tlb_bus.slave)
    );

endmodule

/* testbench/cp0_top_props.sv */
`timescale 1ns/1ps

module cp0_top_props (
    input logic                 clk,
    input logic                 rst,
    input logic                 rd_en,
    input cp0_pkg::cp0_word_t   rd_data,
    input cp0_pkg::cp0_word_t   status,
    input logic                 int_req
);
    import cp0_pkg::*;

    // No interrupt request at exception level.
    no_int_in_exl: assert property (@(posedge clk) disable iff (rst)
        !(int_req && status[STATUS_EXL]))
        else $error("int_req is high while Status.EXL is set");

    status_after_reset: assert property (@(posedge clk) rst |=> status == STATUS_RESET)
        else $error("Status does not hold its reset value after rst");

    // Idle read port drives zero.
    idle_read_zero: assert property (@(posedge clk) !rd_en |-> rd_data == '0)
        else $error("rd_data is nonzero while rd_en is low");

endmodule

/* testbench/cp0_top_tb.sv */
`timescale 1ns/1ps

module cp0_top_tb;
    import cp0_pkg::*;

    localparam int N_EXC   = 20;
    localparam int N_RW    = 60;
    localparam int N_TIMER = 8;
    localparam int N_INT   = 40;
    localparam int N_PROBE = 32;
    // Cycles per iteration of each test plus a margin.
    localparam int MAX_CYCLES = 8 + N_EXC * 8 + 9 + N_RW * 3 + N_TIMER * 60 + N_INT * 4
                                + TLB_ENTRIES * 10 + N_PROBE * 3 + 200;

    logic       clk;
    logic       rst;
    logic       rd_en;
    cp0_addr_t  rd_addr;
    cp0_word_t  rd_data;
    logic       wr_en;
    cp0_addr_t  wr_addr;
    cp0_word_t  wr_data;
    logic [5:0] hw_int;
    logic       exc_valid;
    exc_code_t  exc_code;
    logic       exc_bd;
    cp0_word_t  exc_epc;
    logic       exc_badvaddr_valid;
    cp0_word_t  exc_badvaddr;
    logic       eret;
    logic       tlbp;
    logic       tlbr;
    logic       tlbwi;
    cp0_word_t  epc;
    logic       int_req;

    integer     seed;
    int         cyc = 0;

    // Reference model state.
    cp0_word_t  idx_m, lo0_m, lo1_m, hi_m, bva_m, epc_m, status_m, cmp_m, count_v;
    int         count_cyc;
    logic       ti_m;
    logic       bd_m;
    logic [1:0] sw_m;
    logic [5:0] hw_m;
    exc_code_t  exc_m;
    tlb_entry_t tlb_m [TLB_ENTRIES];
    cp0_addr_t  writable [9] = '{CP0_INDEX, CP0_ENTRYLO0, CP0_ENTRYLO1, CP0_COUNT,
                                 CP0_ENTRYHI, CP0_COMPARE, CP0_STATUS, CP0_CAUSE, CP0_EPC};

    cp0_top dut (.*);

    bind cp0_regs cp0_top_props props (
        .clk     (clk),
        .rst     (rst),
        .rd_en   (rd_en),
        .rd_data (rd_data),
        .status  (status_q),
        .int_req (int_req)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_word(input string what, input cp0_word_t got, input cp0_word_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    function automatic cp0_word_t rand32();
        return $random(seed);
    endfunction

    function automatic cp0_word_t count_now();
        return count_v + cp0_word_t'((cyc - count_cyc) / 2);
    endfunction

    function automatic cp0_word_t cause_model();
        return {bd_m, ti_m, 14'd0, hw_m[5] | ti_m, hw_m[4:0], sw_m, 1'b0, exc_m, 2'b00};
    endfunction

    function automatic logic int_req_model();
        cp0_word_t c;
        c = cause_model();
        return (|(c[15:8] & status_m[15:8])) && status_m[STATUS_IE] && !status_m[STATUS_EXL];
    endfunction

    // Bits of each register that mtc0 can change.
    function automatic cp0_word_t write_mask(input cp0_addr_t a);
        case (a)
            CP0_INDEX:                       return 32'h0000_000f;
            CP0_ENTRYLO0, CP0_ENTRYLO1:      return 32'h03ff_ffff;
            CP0_ENTRYHI:                     return 32'hffff_e0ff;
            CP0_STATUS:                      return 32'h0000_ff03;
            CP0_CAUSE:                       return 32'h0000_0300;
            CP0_COUNT, CP0_COMPARE, CP0_EPC: return 32'hffff_ffff;
            default:                         return 32'h0;
        endcase
    endfunction

    function automatic cp0_word_t model_read(input cp0_addr_t a);
        case (a)
            CP0_INDEX:    return idx_m;
            CP0_ENTRYLO0: return lo0_m;
            CP0_ENTRYLO1: return lo1_m;
            CP0_BADVADDR: return bva_m;
            CP0_COUNT:    return count_now();
            CP0_ENTRYHI:  return hi_m;
            CP0_COMPARE:  return cmp_m;
            CP0_STATUS:   return status_m;
            CP0_CAUSE:    return cause_model();
            CP0_EPC:      return epc_m;
            default:      return 32'h0;
        endcase
    endfunction

    // One clock that also advances the registered hw_int and TI in the model.
    task automatic step();
        logic [5:0] hw_next;
        logic       ti_next;
        hw_next = hw_int;
        ti_next = ti_m;
        if (wr_en && wr_addr == CP0_COMPARE) begin
            ti_next = 1'b0;
        end else if (cmp_m != 32'h0 && count_now() == cmp_m) begin
            ti_next = 1'b1;
        end
        @(posedge clk);
        #1;
        hw_m = hw_next;
        ti_m = ti_next;
    endtask

    task automatic apply_write(input cp0_addr_t a, input cp0_word_t d);
        cp0_word_t m;
        m = write_mask(a);
        case (a)
            CP0_INDEX:    idx_m = d & m;
            CP0_ENTRYLO0: lo0_m = d & m;
            CP0_ENTRYLO1: lo1_m = d & m;
            CP0_ENTRYHI:  hi_m = d & m;
            CP0_STATUS:   status_m = (status_m & ~m) | (d & m);
            CP0_CAUSE:    sw_m = d[9:8];
            CP0_COMPARE:  cmp_m = d;
            CP0_EPC:      epc_m = d;
            CP0_COUNT: begin
                count_v   = d;
                count_cyc = cyc;
            end
            default: ;
        endcase
    endtask

    task automatic mtc0(input cp0_addr_t a, input cp0_word_t d, input logic read_back);
        cp0_word_t m;
        m = write_mask(a);
        wr_en   = 1'b1;
        wr_addr = a;
        wr_data = d;
        rd_en   = read_back;
        rd_addr = a;
        if (read_back) begin
            #20;
            check_word("same-cycle read", rd_data, (model_read(a) & ~m) | (d & m));
        end
        step();
        wr_en = 1'b0;
        rd_en = 1'b0;
        apply_write(a, d);
    endtask

    task automatic read_check(input cp0_addr_t a, output cp0_word_t got);
        cp0_word_t exp;
        exp     = model_read(a);
        rd_en   = 1'b1;
        rd_addr = a;
        #20;
        got = rd_data;
        check_word($sformatf("mfc0 address %h", a), got, exp);
        step();
        rd_en = 1'b0;
    endtask

    initial begin
        cp0_word_t r;
        cp0_word_t v;
        cp0_word_t got;
        int        n;
        int        d;
        seed = 32'ha270_486d;
        rst = 1'b1;
        rd_en = 1'b0;
        rd_addr = '0;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        hw_int = '0;
        exc_valid = 1'b0;
        exc_code = '0;
        exc_bd = 1'b0;
        exc_epc = '0;
        exc_badvaddr_valid = 1'b0;
        exc_badvaddr = '0;
        eret = 1'b0;
        tlbp = 1'b0;
        tlbr = 1'b0;
        tlbwi = 1'b0;
        cmp_m = '0;
        count_v = '0;
        count_cyc = 0;
        ti_m = 1'b0;
        hw_m = '0;
        repeat (8) step();
        rst = 1'b0;
        status_m = STATUS_RESET;
        idx_m = '0;
        sw_m = '0;
        bd_m = 1'b0;
        exc_m = '0;
        count_cyc = cyc;

        // Exceptions with an occasional eret in the same cycle.
        for (int i = 0; i < N_EXC; i++) begin
            r = rand32();
            exc_valid = 1'b1;
            exc_code = r[4:0];
            exc_bd = r[5];
            exc_badvaddr_valid = r[6] || (i == 0);
            eret = r[7];
            exc_epc = rand32();
            exc_badvaddr = rand32();
            step();
            status_m[STATUS_EXL] = 1'b1;
            exc_m = exc_code;
            bd_m = exc_bd;
            epc_m = exc_epc;
            if (exc_badvaddr_valid) begin
                bva_m = exc_badvaddr;
            end
            exc_valid = 1'b0;
            exc_badvaddr_valid = 1'b0;
            eret = 1'b0;
            #20;
            check_word("epc output", epc, epc_m);
            step();
            read_check(CP0_EPC, got);
            read_check(CP0_CAUSE, got);
            read_check(CP0_STATUS, got);
            read_check(CP0_BADVADDR, got);
            eret = 1'b1;
            step();
            eret = 1'b0;
            status_m[STATUS_EXL] = 1'b0;
            read_check(CP0_STATUS, got);
        end

        foreach (writable[k]) begin
            mtc0(writable[k], rand32(), 1'b0);
        end
        for (int i = 0; i < N_RW; i++) begin
            r = rand32();
            mtc0(writable[r[31:28] % 4'd9], rand32(), r[0]);
            read_check(writable[r[31:28] % 4'd9], got);
            read_check(r[15:8], got);
        end

        for (int i = 0; i < N_TIMER; i++) begin
            r = rand32();
            v = {1'b0, r[30:0]};
            mtc0(CP0_COUNT, v, 1'b0);
            r = rand32();
            n = int'(r[3:0]);
            repeat (n) step();
            read_check(CP0_COUNT, got);
            check_word("Count after write", got, v + cp0_word_t'(n / 2));
            d = 2 + int'(r[6:4]);
            mtc0(CP0_COMPARE, count_now() + cp0_word_t'(d), 1'b0);
            got = '0;
            n = 0;
            while (!got[CAUSE_TI] && n < 40) begin
                read_check(CP0_CAUSE, got);
                n++;
            end
            check_bit("Cause.TI once Count reaches Compare", got[CAUSE_TI], 1'b1);
            mtc0(CP0_COMPARE, 32'h0, 1'b0);
            read_check(CP0_CAUSE, got);
            check_bit("Cause.TI after Compare write", got[CAUSE_TI], 1'b0);
        end

        for (int i = 0; i < N_INT; i++) begin
            mtc0(CP0_STATUS, rand32(), 1'b0);
            mtc0(CP0_CAUSE, rand32(), 1'b0);
            r = rand32();
            hw_int = r[5:0];
            step();
            #20;
            check_bit("int_req", int_req, int_req_model());
            step();
        end
        hw_int = '0;
        step();

        // Few VPN2 and ASID values so that probes both hit and miss.
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            r = rand32();
            mtc0(CP0_INDEX, cp0_word_t'(i), 1'b0);
            mtc0(CP0_ENTRYHI, {17'd0, r[1:0], 5'd0, 6'd0, r[3:2]}, 1'b0);
            v = rand32();
            mtc0(CP0_ENTRYLO0, {v[31:1], r[4]}, 1'b0);
            v = rand32();
            mtc0(CP0_ENTRYLO1, {v[31:1], r[5]}, 1'b0);
            tlbwi = 1'b1;
            step();
            tlbwi = 1'b0;
            tlb_m[i].vpn2 = hi_m[31:13];
            tlb_m[i].asid = hi_m[7:0];
            tlb_m[i].g = lo0_m[0] & lo1_m[0];
            tlb_m[i].lo0 = lo0_m[25:1];
            tlb_m[i].lo1 = lo1_m[25:1];
        end
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            mtc0(CP0_INDEX, cp0_word_t'(i), 1'b0);
            tlbr = 1'b1;
            step();
            tlbr = 1'b0;
            hi_m = {tlb_m[i].vpn2, 5'd0, tlb_m[i].asid};
            lo0_m = {6'd0, tlb_m[i].lo0, tlb_m[i].g};
            lo1_m = {6'd0, tlb_m[i].lo1, tlb_m[i].g};
            read_check(CP0_ENTRYHI, got);
            read_check(CP0_ENTRYLO0, got);
            read_check(CP0_ENTRYLO1, got);
        end
        for (int i = 0; i < N_PROBE; i++) begin
            r = rand32();
            mtc0(CP0_ENTRYHI, {16'd0, r[2:0], 5'd0, 6'd0, r[4:3]}, 1'b0);
            tlbp = 1'b1;
            step();
            tlbp = 1'b0;
            idx_m = 32'h8000_0000;
            for (int k = 0; k < TLB_ENTRIES; k++) begin
                if (idx_m[31] && tlb_m[k].vpn2 == hi_m[31:13] &&
                    (tlb_m[k].g || tlb_m[k].asid == hi_m[7:0])) begin
                    idx_m = cp0_word_t'(k);
                end
            end
            read_check(CP0_INDEX, got);
        end

        $display("Everything OK");
        $finish;
    end

endmodule

/* tlb/tlb_array.sv */
`timescale 1ns/1ps

module tlb_array (
    input  logic        clk,
    input  logic        tlbwi,
    cp0_tlb_if.slave    tlb
);
    import cp0_pkg::*;

    tlb_entry_t             mem [TLB_ENTRIES];
    tlb_entry_t             wr_entry;
    logic [TLB_IDX_W-1:0]   sel;
    logic [TLB_ENTRIES-1:0] match;
    logic                   hit;
    logic [TLB_IDX_W-1:0]   hit_idx;

    assign sel = tlb.index[TLB_IDX_W-1:0];

    // Entry is global only when both halves say so.
    always_comb begin
        wr_entry.vpn2 = tlb.entryhi[31:13];
        wr_entry.asid = tlb.entryhi[7:0];
        wr_entry.g    = tlb.entrylo0[0] & tlb.entrylo1[0];
        wr_entry.lo0  = tlb.entrylo0[25:1];
        wr_entry.lo1  = tlb.entrylo1[25:1];
    end

    always_ff @(posedge clk) begin
        if (tlbwi) begin
            mem[sel] <= wr_entry;
        end
    end

    assign tlb.rd_entry = mem[sel];

    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            match[i] = (mem[i].vpn2 == tlb.entryhi[31:13]) &&
                       (mem[i].g || mem[i].asid == tlb.entryhi[7:0]);
        end
    end

    // Scan downward so the lowest matching index is kept.
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit     = 1'b1;
                hit_idx = TLB_IDX_W'(i);
            end
        end
    end

    assign tlb.probe_hit = hit;
    assign tlb.probe_idx = hit_idx;

endmodule
